// ==== periph_pkg.sv ====
// Peripheral subsystem definitions
// Sizes, register map, interrupt IDs and bus types for the timer, GPIO and interrupt controller
package periph_pkg;

  // Pin count and bus widths
  localparam int GPIO_WIDTH     = 8;
  localparam int ADDR_WIDTH     = 8;
  localparam int DATA_WIDTH     = 32;
  localparam int PRESCALE_WIDTH = 16;

  // One timer source plus one source per GPIO pin
  localparam int INTR_NUM_SRC  = 1 + GPIO_WIDTH;
  localparam int INTR_ID_WIDTH = 4;

  // Interrupt IDs, also the slot numbers in the source vector
  localparam logic [INTR_ID_WIDTH-1:0] INTR_ID_NONE      = 4'd0;
  localparam logic [INTR_ID_WIDTH-1:0] INTR_ID_TIMER     = 4'd1;
  // GPIO pin n uses ID n + 2
  localparam logic [INTR_ID_WIDTH-1:0] INTR_ID_GPIO_BASE = 4'd2;

  // Register map, the address doubles as the write opcode
  typedef enum logic [ADDR_WIDTH-1:0] {
    // Bit 0 enables the timer
    REG_TIMER_CTRL      = 8'h00,
    // Low 16 bits, counter advances every prescale+1 cycles
    REG_TIMER_PRESCALE  = 8'h04,
    REG_TIMER_CMP       = 8'h08,
    REG_GPIO_OUT        = 8'h10,
    REG_GPIO_OE         = 8'h14,
    REG_GPIO_INTR_EN    = 8'h18,
    // Write one to clear
    REG_GPIO_INTR_STATE = 8'h1C,
    // Bits 9:1, bit n enables interrupt ID n
    REG_INTR_ENABLE     = 8'h20
  } reg_addr_e;

  // Single-cycle register write, no read path and no back-pressure
  typedef struct packed {
    logic                  write;
    reg_addr_e             addr;
    logic [DATA_WIDTH-1:0] wdata;
  } reg_req_t;

  // Pad drive for the GPIO pins
  typedef struct packed {
    logic [GPIO_WIDTH-1:0] out;
    logic [GPIO_WIDTH-1:0] oe;
  } gpio_pins_t;

endpackage

// ==== soc_timer.sv ====
// System timer
// Prescaled 32-bit up counter with a compare register and a level interrupt
`timescale 1ns/100ps

module soc_timer (
  input  logic                 clk_sys_i,
  input  logic                 rst_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output logic                 timer_intr_o
);

  // Configuration registers
  logic                                  en_q;
  logic                                  en_d;
  logic [periph_pkg::PRESCALE_WIDTH-1:0] prescale_q;
  logic [periph_pkg::PRESCALE_WIDTH-1:0] prescale_d;
  logic [periph_pkg::DATA_WIDTH-1:0]     cmp_q;
  logic [periph_pkg::DATA_WIDTH-1:0]     cmp_d;

  // Counter state
  logic [periph_pkg::PRESCALE_WIDTH-1:0] tick_q;
  logic [periph_pkg::PRESCALE_WIDTH-1:0] tick_d;
  logic [periph_pkg::DATA_WIDTH-1:0]     cnt_q;
  logic [periph_pkg::DATA_WIDTH-1:0]     cnt_d;
  logic                                  intr_q;
  logic                                  intr_d;

  logic wr_ctrl;
  logic wr_prescale;
  logic wr_cmp;

  // Address decode
  assign wr_ctrl     = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_TIMER_CTRL);
  assign wr_prescale = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_TIMER_PRESCALE);
  assign wr_cmp      = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_TIMER_CMP);

  // Register updates
  always_comb begin
    en_d       = wr_ctrl ? reg_req_i.wdata[0] : en_q;
    prescale_d = wr_prescale ? reg_req_i.wdata[periph_pkg::PRESCALE_WIDTH-1:0] : prescale_q;
    cmp_d      = wr_cmp ? reg_req_i.wdata : cmp_q;
  end

  // Counter advance
  // Counting starts the cycle after the enable lands, disable clears everything
  always_comb begin
    tick_d = tick_q;
    cnt_d  = cnt_q;
    if (!en_d) begin
      tick_d = '0;
      cnt_d  = '0;
    end else if (en_q) begin
      if (tick_q >= prescale_q) begin
        tick_d = '0;
        cnt_d  = cnt_q + 1'b1;
      end else begin
        tick_d = tick_q + 1'b1;
      end
    end
  end

  // Level interrupt follows the next-state count and compare
  assign intr_d = en_d && (cnt_d >= cmp_d);

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      en_q       <= 1'b0;
      prescale_q <= '0;
      cmp_q      <= '0;
      tick_q     <= '0;
      cnt_q      <= '0;
      intr_q     <= 1'b0;
    end else begin
      en_q       <= en_d;
      prescale_q <= prescale_d;
      cmp_q      <= cmp_d;
      tick_q     <= tick_d;
      cnt_q      <= cnt_d;
      intr_q     <= intr_d;
    end
  end

  assign timer_intr_o = intr_q;

endmodule

// ==== soc_gpio.sv ====
// GPIO block
// Output and output-enable registers, synchronized inputs, sticky rising-edge interrupts
`timescale 1ns/100ps

module soc_gpio (
  input  logic                                 clk_sys_i,
  input  logic                                 rst_i,
  input  periph_pkg::reg_req_t                 reg_req_i,
  input  logic [periph_pkg::GPIO_WIDTH-1:0]    cio_gpio_i,
  output periph_pkg::gpio_pins_t               gpio_pins_o,
  output logic [periph_pkg::GPIO_WIDTH-1:0]    gpio_intr_o
);

  // Pad drive registers
  periph_pkg::gpio_pins_t pins_q;

  // Input synchronizer and previous sample
  logic [periph_pkg::GPIO_WIDTH-1:0] sync1_q;
  logic [periph_pkg::GPIO_WIDTH-1:0] sync2_q;
  logic [periph_pkg::GPIO_WIDTH-1:0] prev_q;

  // Interrupt enable and sticky state
  logic [periph_pkg::GPIO_WIDTH-1:0] intr_en_q;
  logic [periph_pkg::GPIO_WIDTH-1:0] state_q;
  logic [periph_pkg::GPIO_WIDTH-1:0] state_d;

  logic [periph_pkg::GPIO_WIDTH-1:0] rise;
  logic [periph_pkg::GPIO_WIDTH-1:0] clr;

  logic wr_out;
  logic wr_oe;
  logic wr_intr_en;
  logic wr_state;

  assign wr_out     = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_GPIO_OUT);
  assign wr_oe      = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_GPIO_OE);
  assign wr_intr_en = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_GPIO_INTR_EN);
  assign wr_state   = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_GPIO_INTR_STATE);

  // Edge on the synchronized input
  assign rise = sync2_q & ~prev_q;

  // Write-one-to-clear, a new edge in the same cycle still sets
  assign clr     = wr_state ? reg_req_i.wdata[periph_pkg::GPIO_WIDTH-1:0] : '0;
  assign state_d = (state_q & ~clr) | rise;

  // Output and enable registers
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      pins_q    <= '0;
      intr_en_q <= '0;
    end else begin
      if (wr_out) begin
        pins_q.out <= reg_req_i.wdata[periph_pkg::GPIO_WIDTH-1:0];
      end
      if (wr_oe) begin
        pins_q.oe <= reg_req_i.wdata[periph_pkg::GPIO_WIDTH-1:0];
      end
      if (wr_intr_en) begin
        intr_en_q <= reg_req_i.wdata[periph_pkg::GPIO_WIDTH-1:0];
      end
    end
  end

  // Two-flop synchronizer, then the edge detector history
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= cio_gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // Sticky interrupt state
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  assign gpio_pins_o = pins_q;

  // Pending and enabled
  assign gpio_intr_o = state_q & intr_en_q;

endmodule

// ==== intr_ctrl.sv ====
// Interrupt controller
// Collects timer and GPIO sources, applies the enable mask, picks the lowest pending ID
`timescale 1ns/100ps

module intr_ctrl (
  input  logic                                  clk_sys_i,
  input  logic                                  rst_i,
  input  periph_pkg::reg_req_t                  reg_req_i,
  input  logic                                  timer_intr_i,
  input  logic [periph_pkg::GPIO_WIDTH-1:0]     gpio_intr_i,
  output logic                                  irq_o,
  output logic [periph_pkg::INTR_ID_WIDTH-1:0]  irq_id_o
);

  // Slot numbers equal interrupt IDs, ID 0 means none and has no slot
  logic [periph_pkg::INTR_NUM_SRC:1] src;
  logic [periph_pkg::INTR_NUM_SRC:1] enable_q;
  logic [periph_pkg::INTR_NUM_SRC:1] pending;

  logic wr_enable;

  assign wr_enable = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_INTR_ENABLE);

  // Enable mask, register bit n gates ID n
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      enable_q <= '0;
    end else if (wr_enable) begin
      enable_q <= reg_req_i.wdata[periph_pkg::INTR_NUM_SRC:1];
    end
  end

  // Source vector assembly
  always_comb begin
    src = '0;
    src[periph_pkg::INTR_ID_TIMER] = timer_intr_i;
    src[periph_pkg::INTR_ID_GPIO_BASE +: periph_pkg::GPIO_WIDTH] = gpio_intr_i;
  end

  assign pending = src & enable_q;

  assign irq_o = |pending;

  // Fixed priority, lowest ID wins
  // Scan from the top so the last match is the lowest slot
  always_comb begin
    irq_id_o = periph_pkg::INTR_ID_NONE;
    for (int i = periph_pkg::INTR_NUM_SRC; i >= 1; i--) begin
      if (pending[i]) begin
        irq_id_o = i[periph_pkg::INTR_ID_WIDTH-1:0];
      end
    end
  end

endmodule

// ==== periph_top.sv ====
// Peripheral subsystem top
// Timer and GPIO side by side, both feeding the interrupt controller
`timescale 1ns/100ps

module periph_top (
  // Clock and reset
  input  logic                                 clk_sys_i,
  input  logic                                 rst_i,

  // Register writes
  input  periph_pkg::reg_req_t                 reg_req_i,

  // GPIO pads
  input  logic [periph_pkg::GPIO_WIDTH-1:0]    cio_gpio_i,
  output logic [periph_pkg::GPIO_WIDTH-1:0]    cio_gpio_o,
  output logic [periph_pkg::GPIO_WIDTH-1:0]    cio_gpio_en_o,

  // Interrupt request
  output logic                                 irq_o,
  output logic [periph_pkg::INTR_ID_WIDTH-1:0] irq_id_o
);

  // Interrupt sources
  logic                              timer_intr;
  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_intr;

  periph_pkg::gpio_pins_t gpio_pins;

  soc_timer u_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_i       (rst_i),
    .reg_req_i   (reg_req_i),
    .timer_intr_o(timer_intr)
  );

  soc_gpio u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_i      (rst_i),
    .reg_req_i  (reg_req_i),
    .cio_gpio_i (cio_gpio_i),
    .gpio_pins_o(gpio_pins),
    .gpio_intr_o(gpio_intr)
  );

  intr_ctrl u_intr_ctrl (
    .clk_sys_i   (clk_sys_i),
    .rst_i       (rst_i),
    .reg_req_i   (reg_req_i),
    .timer_intr_i(timer_intr),
    .gpio_intr_i (gpio_intr),
    .irq_o       (irq_o),
    .irq_id_o    (irq_id_o)
  );

  // Pad drive split
  assign cio_gpio_o    = gpio_pins.out;
  assign cio_gpio_en_o = gpio_pins.oe;

endmodule

// ==== periph_top_chk.sv ====
// Peripheral subsystem checker
// Concurrent assertions on pads, interrupt timing and priority for the top
`timescale 1ns/100ps

module periph_top_chk (
  input logic                                 clk_sys_i,
  input logic                                 rst_i,
  input periph_pkg::reg_req_t                 reg_req_i,
  input logic [periph_pkg::GPIO_WIDTH-1:0]    cio_gpio_i,
  input logic [periph_pkg::GPIO_WIDTH-1:0]    gpio_out_i,
  input logic [periph_pkg::GPIO_WIDTH-1:0]    gpio_en_i,
  input logic                                 irq_i,
  input logic [periph_pkg::INTR_ID_WIDTH-1:0] irq_id_i,
  input logic                                 timer_intr_i,
  input logic [periph_pkg::GPIO_WIDTH-1:0]    gpio_intr_i
);

  int err_cnt = 0;

  // Shadow copies of the written registers
  logic [periph_pkg::GPIO_WIDTH-1:0]    out_sh;
  logic [periph_pkg::GPIO_WIDTH-1:0]    oe_sh;
  logic [periph_pkg::GPIO_WIDTH-1:0]    pin_en_sh;
  logic [periph_pkg::INTR_NUM_SRC:1]    mask_sh;
  logic [15:0]                          pre_sh;
  logic [periph_pkg::DATA_WIDTH-1:0]    cmp_sh;
  logic                                 tmr_en_sh;

  // Raw input history and expected edge ID three cycles on
  logic [periph_pkg::GPIO_WIDTH-1:0]    in_prev;
  logic [periph_pkg::INTR_ID_WIDTH-1:0] edge_id;
  logic [periph_pkg::INTR_ID_WIDTH-1:0] edge_id_d1;
  logic [periph_pkg::INTR_ID_WIDTH-1:0] edge_id_d2;
  logic [periph_pkg::INTR_ID_WIDTH-1:0] edge_id_d3;
  logic [periph_pkg::INTR_ID_WIDTH-1:0] exp_id;

  // Timer countdown from the enable write
  logic                                 armed;
  logic [periph_pkg::DATA_WIDTH-1:0]    wait_cnt;

  logic wr_ctrl;
  logic wr_out;
  logic wr_oe;
  logic wr_state;

  // Lowest set slot wins and zero means none
  function automatic logic [periph_pkg::INTR_ID_WIDTH-1:0] lowest_id(
    input logic [periph_pkg::INTR_NUM_SRC:1] vec
  );
    logic [periph_pkg::INTR_ID_WIDTH-1:0] id;
    id = periph_pkg::INTR_ID_NONE;
    for (int k = 1; k <= periph_pkg::INTR_NUM_SRC; k++) begin
      if (vec[k] && id == periph_pkg::INTR_ID_NONE) begin
        id = periph_pkg::INTR_ID_WIDTH'(k);
      end
    end
    return id;
  endfunction

  assign wr_ctrl  = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_TIMER_CTRL);
  assign wr_out   = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_GPIO_OUT);
  assign wr_oe    = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_GPIO_OE);
  assign wr_state = reg_req_i.write && (reg_req_i.addr == periph_pkg::REG_GPIO_INTR_STATE);

  assign edge_id = lowest_id({cio_gpio_i & ~in_prev & pin_en_sh, 1'b0} & mask_sh);
  assign exp_id  = lowest_id({gpio_intr_i, timer_intr_i} & mask_sh);

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      {out_sh, oe_sh, pin_en_sh, mask_sh} <= '0;
      {pre_sh, cmp_sh, tmr_en_sh}         <= '0;
      {in_prev, edge_id_d1, edge_id_d2, edge_id_d3} <= '0;
    end else begin
      in_prev    <= cio_gpio_i;
      edge_id_d1 <= edge_id;
      edge_id_d2 <= edge_id_d1;
      edge_id_d3 <= edge_id_d2;
      if (reg_req_i.write) begin
        case (reg_req_i.addr)
          periph_pkg::REG_TIMER_CTRL:     tmr_en_sh <= reg_req_i.wdata[0];
          periph_pkg::REG_TIMER_PRESCALE: pre_sh    <= reg_req_i.wdata[15:0];
          periph_pkg::REG_TIMER_CMP:      cmp_sh    <= reg_req_i.wdata;
          periph_pkg::REG_GPIO_OUT:       out_sh    <= reg_req_i.wdata[7:0];
          periph_pkg::REG_GPIO_OE:        oe_sh     <= reg_req_i.wdata[7:0];
          periph_pkg::REG_GPIO_INTR_EN:   pin_en_sh <= reg_req_i.wdata[7:0];
          periph_pkg::REG_INTR_ENABLE:    mask_sh   <= reg_req_i.wdata[9:1];
          default: ;
        endcase
      end
    end
  end

  // Armed only when the timer starts from idle with its source enabled
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      armed    <= 1'b0;
      wait_cnt <= '0;
    end else if (wr_ctrl && reg_req_i.wdata[0] && !tmr_en_sh && mask_sh[1] && !irq_i) begin
      armed    <= 1'b1;
      wait_cnt <= cmp_sh * (32'(pre_sh) + 32'd1);
    end else if (wr_ctrl && !reg_req_i.wdata[0]) begin
      armed <= 1'b0;
    end else if (armed) begin
      if (wait_cnt == '0) begin
        armed <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 32'd1;
      end
    end
  end

  a_reset: assert property (@(posedge clk_sys_i)
    rst_i |=> (gpio_out_i == '0 && gpio_en_i == '0 && !irq_i && irq_id_i == '0))
    else begin
      err_cnt++;
      $error("Mismatch reset: expected out 00 oe 00 irq 0 id 0, actual out %h oe %h irq %b id %0d",
             $sampled(gpio_out_i), $sampled(gpio_en_i), $sampled(irq_i), $sampled(irq_id_i));
    end

  a_gpio_out: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    wr_out |=> gpio_out_i == out_sh)
    else begin
      err_cnt++;
      $error("Mismatch gpio_out: expected %h, actual %h", $sampled(out_sh), $sampled(gpio_out_i));
    end

  a_gpio_oe: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    wr_oe |=> gpio_en_i == oe_sh)
    else begin
      err_cnt++;
      $error("Mismatch gpio_oe: expected %h, actual %h", $sampled(oe_sh), $sampled(gpio_en_i));
    end

  // No request before the synchronizer and edge detector have passed the edge
  a_gpio_edge_early: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    (!irq_i && edge_id != '0) |=> !irq_i ##1 !irq_i)
    else begin
      err_cnt++;
      $error("Mismatch gpio_edge_early: expected irq 0, actual irq %b", $sampled(irq_i));
    end

  a_gpio_edge: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    (!irq_i && edge_id != '0) |-> ##3 (irq_i && irq_id_i == edge_id_d3))
    else begin
      err_cnt++;
      $error("Mismatch gpio_edge: expected irq 1 id %0d, actual irq %b id %0d",
             $sampled(edge_id_d3), $sampled(irq_i), $sampled(irq_id_i));
    end

  a_gpio_clear: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    (wr_state && !timer_intr_i && (gpio_intr_i & ~reg_req_i.wdata[7:0]) == '0) |=> !irq_i)
    else begin
      err_cnt++;
      $error("Mismatch gpio_clear: expected irq 0, actual irq %b", $sampled(irq_i));
    end

  a_timer_wait: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    (armed && wait_cnt != '0) |-> !irq_i)
    else begin
      err_cnt++;
      $error("Mismatch timer_wait: expected irq 0, actual irq %b", $sampled(irq_i));
    end

  a_timer_fire: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    (armed && wait_cnt == '0) |-> (irq_i && irq_id_i == periph_pkg::INTR_ID_TIMER))
    else begin
      err_cnt++;
      $error("Mismatch timer_fire: expected irq 1 id 1, actual irq %b id %0d",
             $sampled(irq_i), $sampled(irq_id_i));
    end

  a_timer_off: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    (wr_ctrl && !reg_req_i.wdata[0] && gpio_intr_i == '0) |=> !irq_i)
    else begin
      err_cnt++;
      $error("Mismatch timer_off: expected irq 0, actual irq %b", $sampled(irq_i));
    end

  // Covers fixed priority and the enable mask in every cycle
  a_priority: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    irq_id_i == exp_id && irq_i == (exp_id != '0))
    else begin
      err_cnt++;
      $error("Mismatch priority: expected id %0d, actual irq %b id %0d",
             $sampled(exp_id), $sampled(irq_i), $sampled(irq_id_i));
    end

endmodule

bind periph_top periph_top_chk u_chk (
  .clk_sys_i   (clk_sys_i),
  .rst_i       (rst_i),
  .reg_req_i   (reg_req_i),
  .cio_gpio_i  (cio_gpio_i),
  .gpio_out_i  (cio_gpio_o),
  .gpio_en_i   (cio_gpio_en_o),
  .irq_i       (irq_o),
  .irq_id_i    (irq_id_o),
  .timer_intr_i(timer_intr),
  .gpio_intr_i (gpio_intr)
);

// ==== tb_periph_top.sv ====
// Peripheral subsystem testbench
// Drives register writes and pad inputs while the bound checker compares the responses
`timescale 1ns/100ps

module tb_periph_top;

  // Bound on the run length in clock cycles
  localparam int CYCLE_LIMIT = 2000;

  logic                                 clk_sys;
  logic                                 rst;
  periph_pkg::reg_req_t                 reg_req;
  logic [periph_pkg::GPIO_WIDTH-1:0]    gpio_in;
  logic [periph_pkg::GPIO_WIDTH-1:0]    gpio_out;
  logic [periph_pkg::GPIO_WIDTH-1:0]    gpio_en;
  logic                                 irq;
  logic [periph_pkg::INTR_ID_WIDTH-1:0] irq_id;

  int seed;
  int tb_err = 0;
  int cycle_cnt = 0;
  int pin;
  logic [periph_pkg::INTR_ID_WIDTH-1:0] pin_id;

  periph_top UUT (
    .clk_sys_i    (clk_sys),
    .rst_i        (rst),
    .reg_req_i    (reg_req),
    .cio_gpio_i   (gpio_in),
    .cio_gpio_o   (gpio_out),
    .cio_gpio_en_o(gpio_en),
    .irq_o        (irq),
    .irq_id_o     (irq_id)
  );

  initial clk_sys = 1'b0;
  always #4 clk_sys = ~clk_sys;

  always @(posedge clk_sys) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_sys);
      #1;
    end
  endtask

  // One-cycle write issued 1 ns after a rising edge
  task automatic write_reg(input periph_pkg::reg_addr_e addr, input logic [31:0] data);
    reg_req.write = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    @(posedge clk_sys);
    #1;
    reg_req.write = 1'b0;
  endtask

  task automatic wait_irq_id(input logic [3:0] id, input int limit, input string what);
    int n;
    n = 0;
    while (irq_id !== id && n < limit) begin
      @(posedge clk_sys);
      #1;
      n++;
    end
    if (irq_id !== id) begin
      tb_err++;
      $display("Error: %s never showed interrupt ID %0d within %0d cycles", what, id, limit);
    end
  endtask

  initial begin
    seed    = 32'ha3f3_cc6a;
    rst     = 1'b1;
    reg_req = '0;
    gpio_in = '0;
    repeat (2) @(posedge clk_sys);
    #1;
    rst = 1'b0;
    idle_cycles(2);

    // Pad output registers
    write_reg(periph_pkg::REG_GPIO_OUT, $random(seed));
    write_reg(periph_pkg::REG_GPIO_OE, $random(seed));
    write_reg(periph_pkg::REG_GPIO_OUT, $random(seed));
    idle_cycles(1);

    // Edge interrupt on one pin, then write-one-to-clear
    pin    = $unsigned($random(seed)) % periph_pkg::GPIO_WIDTH;
    pin_id = periph_pkg::INTR_ID_GPIO_BASE + 4'(pin);
    write_reg(periph_pkg::REG_GPIO_INTR_EN, 32'd1 << pin);
    write_reg(periph_pkg::REG_INTR_ENABLE, 32'd1 << (pin + 2));
    gpio_in[pin] = 1'b1;
    wait_irq_id(pin_id, 10, "GPIO edge");
    write_reg(periph_pkg::REG_GPIO_INTR_STATE, 32'd1 << pin);
    gpio_in[pin] = 1'b0;
    idle_cycles(4);

    // Timer with prescale 3 and compare 10
    write_reg(periph_pkg::REG_INTR_ENABLE, 32'd1 << 1);
    write_reg(periph_pkg::REG_TIMER_PRESCALE, 32'd3);
    write_reg(periph_pkg::REG_TIMER_CMP, 32'd10);
    write_reg(periph_pkg::REG_TIMER_CTRL, 32'd1);
    wait_irq_id(periph_pkg::INTR_ID_TIMER, 60, "Timer");
    idle_cycles(1);
    write_reg(periph_pkg::REG_TIMER_CTRL, 32'd0);
    idle_cycles(2);

    // Timer and a pin both pending, then masking
    pin    = $unsigned($random(seed)) % periph_pkg::GPIO_WIDTH;
    pin_id = periph_pkg::INTR_ID_GPIO_BASE + 4'(pin);
    write_reg(periph_pkg::REG_GPIO_INTR_EN, 32'd1 << pin);
    write_reg(periph_pkg::REG_INTR_ENABLE, (32'd1 << 1) | (32'd1 << (pin + 2)));
    gpio_in[pin] = 1'b1;
    wait_irq_id(pin_id, 10, "GPIO edge with timer enabled");
    write_reg(periph_pkg::REG_TIMER_PRESCALE, 32'd0);
    write_reg(periph_pkg::REG_TIMER_CMP, 32'd2);
    write_reg(periph_pkg::REG_TIMER_CTRL, 32'd1);
    wait_irq_id(periph_pkg::INTR_ID_TIMER, 20, "Timer over pending GPIO");
    write_reg(periph_pkg::REG_INTR_ENABLE, 32'd1 << (pin + 2));
    idle_cycles(1);
    write_reg(periph_pkg::REG_INTR_ENABLE, 32'd0);
    idle_cycles(3);

    $display("Errors: %0d (assertions %0d, testbench %0d)",
             UUT.u_chk.err_cnt + tb_err, UUT.u_chk.err_cnt, tb_err);
    if (UUT.u_chk.err_cnt == 0 && tb_err == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
periph_pkg.sv
soc_timer.sv
soc_gpio.sv
intr_ctrl.sv
periph_top.sv
periph_top_chk.sv
tb_periph_top.sv
